// File: bench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Low through the first three rising edges
  initial begin
    rst_no <= 1'b0;
    repeat (3) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: bench/tb_commit_trace.sv
`timescale 1ns/100ps

module tb_commit_trace;

  localparam int unsigned NR          = trace_pkg::NR_COMMIT_PORTS;
  localparam int unsigned RAND_CYCLES = 2000;
  // Reset, random phase, then room for the queues and capture stage to empty
  localparam int unsigned CYCLE_LIMIT = 3 + RAND_CYCLES + 64;

  logic                             clk;
  logic                             rst_n;
  trace_pkg::commit_port_t [NR-1:0] commit;
  trace_pkg::priv_lvl_e             priv_lvl;
  logic                             debug_mode;
  logic                             trace_ready;
  logic                             trace_valid;
  trace_pkg::trace_rec_t            trace_rec;
  logic [trace_pkg::PORT_IDX_W-1:0] trace_port;
  trace_pkg::drop_vec_t             drop_cnt;
  logic                             model_idle;
  int unsigned                      err_cnt;
  int unsigned                      check_cnt;
  int unsigned                      cycle_cnt = 0;
  logic [31:0]                      lfsr_q;

  tb_clock i_tb_clock (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  commit_trace DUT (
    .clk_i         ( clk         ),
    .rst_ni        ( rst_n       ),
    .commit_i      ( commit      ),
    .priv_lvl_i    ( priv_lvl    ),
    .debug_mode_i  ( debug_mode  ),
    .trace_ready_i ( trace_ready ),
    .trace_valid_o ( trace_valid ),
    .trace_rec_o   ( trace_rec   ),
    .trace_port_o  ( trace_port  ),
    .drop_cnt_o    ( drop_cnt    )
  );

  trace_checker i_trace_checker (
    .clk_i         ( clk         ),
    .rst_ni        ( rst_n       ),
    .commit_i      ( commit      ),
    .priv_lvl_i    ( priv_lvl    ),
    .debug_mode_i  ( debug_mode  ),
    .trace_ready_i ( trace_ready ),
    .trace_valid_i ( trace_valid ),
    .trace_rec_i   ( trace_rec   ),
    .trace_port_i  ( trace_port  ),
    .drop_cnt_i    ( drop_cnt    ),
    .idle_o        ( model_idle  ),
    .err_cnt_o     ( err_cnt     ),
    .check_cnt_o   ( check_cnt   )
  );

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int unsigned n, output logic [63:0] v);
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[62:0], lfsr_q[0]};
    end
  endtask

  task automatic drive_random();
    logic [63:0]                      r;
    trace_pkg::commit_port_t [NR-1:0] c;
    for (int p = 0; p < NR; p++) begin
      take_bits(3, r);
      c[p].ack = (r[2:0] < 3'd3);
      take_bits(2, r);
      c[p].ex_valid = (r[1:0] == 2'd0);
      take_bits(trace_pkg::CAUSE_W, r);
      c[p].cause = r[trace_pkg::CAUSE_W-1:0];
      take_bits(trace_pkg::VLEN, r);
      c[p].pc = r[trace_pkg::VLEN-1:0];
      take_bits(trace_pkg::VLEN, r);
      c[p].tval = r[trace_pkg::VLEN-1:0];
    end
    commit <= c;
    take_bits(2, r);
    // Encoding 2 is reserved, folded onto M
    priv_lvl <= (r[1:0] == 2'd2) ? trace_pkg::PRIV_LVL_M : trace_pkg::priv_lvl_e'(r[1:0]);
    take_bits(3, r);
    debug_mode <= (r[2:0] == 3'd0);
    take_bits(2, r);
    trace_ready <= (r[1:0] != 2'd0);
  endtask

  initial begin
    lfsr_q = 32'h6b12;
    commit      <= '0;
    priv_lvl    <= trace_pkg::PRIV_LVL_M;
    debug_mode  <= 1'b0;
    trace_ready <= 1'b0;
    wait (rst_n === 1'b1);
    repeat (RAND_CYCLES) begin
      @(posedge clk);
      drive_random();
    end
    // Drain with the output always ready
    @(posedge clk);
    commit      <= '0;
    debug_mode  <= 1'b0;
    trace_ready <= 1'b1;
    @(negedge clk);
    while (!(model_idle && !trace_valid)) begin
      @(negedge clk);
    end
    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the trace output never drained", cycle_cnt);
      $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
      $display("sim failed");
      $finish;
    end
  end

endmodule

// File: bench/trace_checker.sv
`timescale 1ns/100ps

module trace_checker (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  trace_pkg::commit_port_t [trace_pkg::NR_COMMIT_PORTS-1:0] commit_i,
  input  trace_pkg::priv_lvl_e                                  priv_lvl_i,
  input  logic                                                  debug_mode_i,
  input  logic                                                  trace_ready_i,
  input  logic                                                  trace_valid_i,
  input  trace_pkg::trace_rec_t                                 trace_rec_i,
  input  logic [trace_pkg::PORT_IDX_W-1:0]                      trace_port_i,
  input  trace_pkg::drop_vec_t                                  drop_cnt_i,
  output logic                                                  idle_o,
  output int unsigned                                           err_cnt_o,
  output int unsigned                                           check_cnt_o
);

  localparam int unsigned NR = trace_pkg::NR_COMMIT_PORTS;

  trace_pkg::trace_rec_t            model_q [NR][$];
  trace_pkg::trace_rec_t            pend_rec [NR];
  logic [NR-1:0]                    pend_vld;
  trace_pkg::drop_vec_t             exp_drop;
  logic [trace_pkg::STAMP_W-1:0]    cycle_q;
  logic [trace_pkg::PORT_IDX_W-1:0] rr_ptr;
  logic                             held;
  logic [trace_pkg::PORT_IDX_W-1:0] held_port;

  initial begin
    err_cnt_o   = 0;
    check_cnt_o = 0;
    idle_o      = 1'b0;
  end

  // Expected record for one acked commit port
  function automatic trace_pkg::trace_rec_t model_record(
    input trace_pkg::commit_port_t     c,
    input trace_pkg::priv_lvl_e        priv,
    input logic                        dbg,
    input logic [trace_pkg::STAMP_W-1:0] stamp
  );
    trace_pkg::trace_rec_t r;
    r.kind = trace_pkg::REC_RETIRE;
    if (c.ex_valid && !dbg) begin
      r.kind = trace_pkg::REC_EXCEPTION;
    end
    if (dbg) begin
      r.mode = trace_pkg::MODE_D;
    end else if (priv == trace_pkg::PRIV_LVL_U) begin
      r.mode = trace_pkg::MODE_U;
    end else if (priv == trace_pkg::PRIV_LVL_S) begin
      r.mode = trace_pkg::MODE_S;
    end else begin
      r.mode = trace_pkg::MODE_M;
    end
    r.stamp = stamp;
    r.pc    = c.pc;
    r.insn  = c.tval[31:0];
    r.cause = c.cause;
    return r;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    check_cnt_o++;
    if (exp !== got) begin
      err_cnt_o++;
      $display("** Error at %0t: %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  task automatic report_failure(input string msg);
    err_cnt_o++;
    $display("Failure at %0t: %s", $time, msg);
  endtask

  // ----------------------------------------
  // One clock of the reference model
  // ----------------------------------------
  task automatic step_model();
    logic [NR-1:0]         full;
    int unsigned           busy;
    int unsigned           p;
    trace_pkg::trace_rec_t exp;
    busy = 0;
    for (int i = 0; i < NR; i++) begin
      full[i] = (model_q[i].size() == trace_pkg::TRACE_DEPTH);
      if (model_q[i].size() != 0) begin
        busy++;
      end
      check_value($sformatf("drop_cnt_o[%0d]", i), 64'(exp_drop[i]), 64'(drop_cnt_i[i]));
    end
    check_value("trace_valid_o", 64'(busy != 0), 64'(trace_valid_i));
    // A stalled output keeps its port and two waiting queues follow the pointer
    if (held && trace_valid_i) begin
      check_value("trace_port_o", 64'(held_port), 64'(trace_port_i));
    end else if (trace_valid_i && busy > 1) begin
      check_value("trace_port_o", 64'(rr_ptr), 64'(trace_port_i));
    end
    p = trace_port_i;
    if (trace_valid_i && model_q[p].size() == 0) begin
      report_failure($sformatf("record shown on port %0d with nothing queued there", p));
    end else if (trace_valid_i) begin
      exp = model_q[p][0];
      check_value("trace_rec_o.kind", 64'(exp.kind), 64'(trace_rec_i.kind));
      check_value("trace_rec_o.mode", 64'(exp.mode), 64'(trace_rec_i.mode));
      check_value("trace_rec_o.stamp", 64'(exp.stamp), 64'(trace_rec_i.stamp));
      check_value("trace_rec_o.pc", 64'(exp.pc), 64'(trace_rec_i.pc));
      check_value("trace_rec_o.insn", 64'(exp.insn), 64'(trace_rec_i.insn));
      check_value("trace_rec_o.cause", 64'(exp.cause), 64'(trace_rec_i.cause));
      if (trace_ready_i) begin
        void'(model_q[p].pop_front());
        rr_ptr = trace_pkg::PORT_IDX_W'((p + 1) % NR);
      end
    end
    held      = trace_valid_i && !trace_ready_i;
    held_port = trace_port_i;
    // Records built last cycle meet the queue state of this cycle
    for (int i = 0; i < NR; i++) begin
      if (pend_vld[i] && full[i]) begin
        if (exp_drop[i] != '1) begin
          exp_drop[i] = exp_drop[i] + 1'b1;
        end
      end else if (pend_vld[i]) begin
        model_q[i].push_back(pend_rec[i]);
      end
    end
    idle_o = 1'b1;
    for (int i = 0; i < NR; i++) begin
      pend_vld[i] = commit_i[i].ack;
      pend_rec[i] = model_record(commit_i[i], priv_lvl_i, debug_mode_i, cycle_q);
      if (pend_vld[i] || model_q[i].size() != 0) begin
        idle_o = 1'b0;
      end
    end
    cycle_q = cycle_q + 1;
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < NR; i++) begin
        model_q[i].delete();
      end
      pend_vld = '0;
      exp_drop = '0;
      cycle_q  = '0;
      rr_ptr   = '0;
      held     = 1'b0;
    end else begin
      step_model();
    end
  end

endmodule

// File: commit_trace.f
hdl/trace_pkg.sv
hdl/trace_capture.sv
hdl/trace_fifo.sv
hdl/trace_arbiter.sv
hdl/commit_trace.sv
bench/tb_clock.sv
bench/trace_checker.sv
bench/tb_commit_trace.sv

// File: hdl/commit_trace.sv
`timescale 1ns/100ps

module commit_trace (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  trace_pkg::commit_port_t [trace_pkg::NR_COMMIT_PORTS-1:0] commit_i,
  input  trace_pkg::priv_lvl_e                                  priv_lvl_i,
  input  logic                                                  debug_mode_i,
  input  logic                                                  trace_ready_i,
  output logic                                                  trace_valid_o,
  output trace_pkg::trace_rec_t                                 trace_rec_o,
  output logic [trace_pkg::PORT_IDX_W-1:0]                      trace_port_o,
  output trace_pkg::drop_vec_t                                  drop_cnt_o
);

  logic [trace_pkg::NR_COMMIT_PORTS-1:0] push;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0] full;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0] not_empty;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0] pop;
  trace_pkg::trace_vec_t                 cap_rec;
  trace_pkg::trace_vec_t                 head_rec;

  // ----------------------------------------
  // Record producer
  // ----------------------------------------
  trace_capture i_trace_capture (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .commit_i     ( commit_i     ),
    .priv_lvl_i   ( priv_lvl_i   ),
    .debug_mode_i ( debug_mode_i ),
    .full_i       ( full         ),
    .push_o       ( push         ),
    .rec_o        ( cap_rec      ),
    .drop_cnt_o   ( drop_cnt_o   )
  );

  // ----------------------------------------
  // Per-port queues
  // ----------------------------------------
  for (genvar i = 0; i < trace_pkg::NR_COMMIT_PORTS; i++) begin : gen_port_fifo
    trace_fifo #(
      .DEPTH ( trace_pkg::TRACE_DEPTH )
    ) i_trace_fifo (
      .clk_i       ( clk_i        ),
      .rst_ni      ( rst_ni       ),
      .push_i      ( push[i]      ),
      .rec_i       ( cap_rec[i]   ),
      .full_o      ( full[i]      ),
      .not_empty_o ( not_empty[i] ),
      .pop_i       ( pop[i]       ),
      .rec_o       ( head_rec[i]  )
    );
  end

  // ----------------------------------------
  // Output merge
  // ----------------------------------------
  trace_arbiter i_trace_arbiter (
    .clk_i   ( clk_i         ),
    .rst_ni  ( rst_ni        ),
    .req_i   ( not_empty     ),
    .rec_i   ( head_rec      ),
    .pop_o   ( pop           ),
    .valid_o ( trace_valid_o ),
    .ready_i ( trace_ready_i ),
    .rec_o   ( trace_rec_o   ),
    .port_o  ( trace_port_o  )
  );

endmodule

// File: hdl/trace_arbiter.sv
`timescale 1ns/100ps

module trace_arbiter (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0] req_i,
  input  trace_pkg::trace_vec_t                 rec_i,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0] pop_o,
  output logic                                  valid_o,
  input  logic                                  ready_i,
  output trace_pkg::trace_rec_t                 rec_o,
  output logic [trace_pkg::PORT_IDX_W-1:0]      port_o
);

  localparam int unsigned NR = trace_pkg::NR_COMMIT_PORTS;
  localparam int unsigned IW = trace_pkg::PORT_IDX_W;

  logic [IW-1:0] rr_ptr_q;
  logic [IW-1:0] gnt_q;
  logic          lock_q;
  logic [IW-1:0] sel_idx;
  logic [IW-1:0] idx;
  logic [IW-1:0] idx_next;
  logic          xfer;

  // ----------------------------------------
  // Round-robin search
  // ----------------------------------------
  // First requester at or after the pointer
  always_comb begin
    logic found;
    found   = 1'b0;
    sel_idx = rr_ptr_q;
    for (int k = 0; k < NR; k++) begin
      if (!found && req_i[(int'(rr_ptr_q) + k) % NR]) begin
        found   = 1'b1;
        sel_idx = IW'((int'(rr_ptr_q) + k) % NR);
      end
    end
  end

  // Stalled output keeps the earlier choice
  assign idx      = lock_q ? gnt_q : sel_idx;
  assign idx_next = (idx == IW'(NR - 1)) ? '0 : idx + IW'(1);

  assign valid_o = |req_i;
  assign xfer    = valid_o && ready_i;
  assign rec_o   = rec_i[idx];
  assign port_o  = idx;

  always_comb begin
    pop_o = '0;
    if (xfer) begin
      pop_o[idx] = 1'b1;
    end
  end

  // ----------------------------------------
  // Pointer and lock
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_ptr_q <= '0;
      gnt_q    <= '0;
      lock_q   <= 1'b0;
    end else if (xfer) begin
      rr_ptr_q <= idx_next;
      lock_q   <= 1'b0;
    end else if (valid_o) begin
      gnt_q  <= idx;
      lock_q <= 1'b1;
    end
  end

  a_hold_on_stall: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(rec_o) && $stable(port_o)
  );

endmodule

// File: hdl/trace_capture.sv
`timescale 1ns/100ps

module trace_capture (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  trace_pkg::commit_port_t [trace_pkg::NR_COMMIT_PORTS-1:0] commit_i,
  input  trace_pkg::priv_lvl_e                                  priv_lvl_i,
  input  logic                                                  debug_mode_i,
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                 full_i,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0]                 push_o,
  output trace_pkg::trace_vec_t                                 rec_o,
  output trace_pkg::drop_vec_t                                  drop_cnt_o
);

  logic [trace_pkg::STAMP_W-1:0]         cycle_q;
  trace_pkg::trace_mode_e                mode;
  trace_pkg::trace_vec_t                 rec_d;
  trace_pkg::trace_vec_t                 rec_q;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0] valid_q;
  trace_pkg::drop_vec_t                  drop_q;

  // ----------------------------------------
  // Cycle stamp
  // ----------------------------------------
  // Reads 0 in the first cycle out of reset and wraps freely
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + trace_pkg::STAMP_W'(1);
    end
  end

  // Debug mode overrides the privilege level
  always_comb begin
    if (debug_mode_i) begin
      mode = trace_pkg::MODE_D;
    end else begin
      case (priv_lvl_i)
        trace_pkg::PRIV_LVL_U: mode = trace_pkg::MODE_U;
        trace_pkg::PRIV_LVL_S: mode = trace_pkg::MODE_S;
        default:               mode = trace_pkg::MODE_M;
      endcase
    end
  end

  // ----------------------------------------
  // Record build
  // ----------------------------------------
  always_comb begin
    for (int i = 0; i < trace_pkg::NR_COMMIT_PORTS; i++) begin
      // An exception taken in debug mode is logged as a plain retire
      if (commit_i[i].ex_valid && !debug_mode_i) begin
        rec_d[i].kind = trace_pkg::REC_EXCEPTION;
      end else begin
        rec_d[i].kind = trace_pkg::REC_RETIRE;
      end
      rec_d[i].mode  = mode;
      rec_d[i].stamp = cycle_q;
      rec_d[i].pc    = commit_i[i].pc;
      rec_d[i].insn  = commit_i[i].tval[31:0];
      rec_d[i].cause = commit_i[i].cause;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      for (int i = 0; i < trace_pkg::NR_COMMIT_PORTS; i++) begin
        valid_q[i] <= commit_i[i].ack;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rec_q <= rec_d;
  end

  // ----------------------------------------
  // Push or drop
  // ----------------------------------------
  // A record meeting a full queue is lost since commit never stalls
  assign push_o = valid_q & ~full_i;
  assign rec_o  = rec_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      drop_q <= '0;
    end else begin
      for (int i = 0; i < trace_pkg::NR_COMMIT_PORTS; i++) begin
        if (valid_q[i] && full_i[i] && (drop_q[i] != {trace_pkg::DROP_W{1'b1}})) begin
          drop_q[i] <= drop_q[i] + trace_pkg::DROP_W'(1);
        end
      end
    end
  end

  assign drop_cnt_o = drop_q;

endmodule

// File: hdl/trace_fifo.sv
`timescale 1ns/100ps

module trace_fifo #(
  parameter int unsigned DEPTH = trace_pkg::TRACE_DEPTH
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_i,
  input  trace_pkg::trace_rec_t rec_i,
  output logic                  full_o,
  output logic                  not_empty_o,
  input  logic                  pop_i,
  output trace_pkg::trace_rec_t rec_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  trace_pkg::trace_rec_t mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_next;
  logic [PTR_W-1:0] rd_ptr_next;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_d;
  logic             full_q;

  initial begin
    assert (DEPTH >= 2);
  end

  // ----------------------------------------
  // Pointers and occupancy
  // ----------------------------------------
  // Explicit wrap so DEPTH need not be a power of two
  assign wr_ptr_next = (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
  assign rd_ptr_next = (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);

  always_comb begin
    count_d = count_q;
    case ({push_i, pop_i})
      2'b10:   count_d = count_q + CNT_W'(1);
      2'b01:   count_d = count_q - CNT_W'(1);
      default: count_d = count_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      full_q   <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_next;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_next;
      end
      count_q <= count_d;
      full_q  <= (count_d == CNT_W'(DEPTH));
    end
  end

  // ----------------------------------------
  // Storage
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= rec_i;
    end
  end

  // Head is read without a register stage
  assign rec_o       = mem_q[rd_ptr_q];
  assign full_o      = full_q;
  assign not_empty_o = (count_q != '0);

  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o
  );

  a_no_pop_empty: assert property (
    @(posedge clk_i) disable iff (!rst_ni) pop_i |-> not_empty_o
  );

endmodule

// File: hdl/trace_pkg.sv
package trace_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------
  localparam int unsigned NR_COMMIT_PORTS = 2;
  localparam int unsigned VLEN            = 64;
  localparam int unsigned STAMP_W         = 32;
  localparam int unsigned CAUSE_W         = 6;
  localparam int unsigned TRACE_DEPTH     = 4;
  localparam int unsigned DROP_W          = 16;
  localparam int unsigned PORT_IDX_W      = 1;

  // ----------------------------------------
  // Encodings
  // ----------------------------------------
  // RISC-V privilege levels, 2 is reserved
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_S = 2'd1,
    PRIV_LVL_M = 2'd3
  } priv_lvl_e;

  // Mode letter of a record, D sits in the reserved privilege slot
  typedef enum logic [1:0] {
    MODE_U = 2'd0,
    MODE_S = 2'd1,
    MODE_D = 2'd2,
    MODE_M = 2'd3
  } trace_mode_e;

  typedef enum logic {
    REC_RETIRE    = 1'b0,
    REC_EXCEPTION = 1'b1
  } rec_kind_e;

  // ----------------------------------------
  // Records
  // ----------------------------------------
  // One commit port as seen from the commit stage
  typedef struct packed {
    logic               ack;
    logic [VLEN-1:0]    pc;
    logic               ex_valid;
    logic [CAUSE_W-1:0] cause;
    logic [VLEN-1:0]    tval;
  } commit_port_t;

  typedef struct packed {
    rec_kind_e          kind;
    trace_mode_e        mode;
    logic [STAMP_W-1:0] stamp;
    logic [VLEN-1:0]    pc;
    logic [31:0]        insn;   // low word of tval
    logic [CAUSE_W-1:0] cause;
  } trace_rec_t;

  typedef trace_rec_t [NR_COMMIT_PORTS-1:0] trace_vec_t;

  typedef logic [NR_COMMIT_PORTS-1:0][DROP_W-1:0] drop_vec_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build and run the commit trace testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_commit_trace -f commit_trace.f -o sim_commit_trace

./obj_dir/sim_commit_trace | tee sim.log

if grep -qx "sim passed" sim.log; then
  exit 0
else
  exit 1
fi
